// ==== rtl/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// 32 lines of one word each
`define DCACHE_INDEX_WID 5
`define DCACHE_ADDR_WID 32
`define DCACHE_DATA_WID 32
// tag covers addr[15:index+2]
`define DCACHE_TAG_WID (14 - `DCACHE_INDEX_WID)

// addr[19:16] value selecting io
`define MMIO_REGION 4'hf
`define RAM_LATENCY 3
`define RAM_WORDS 16384

`endif

// ==== rtl/dcache_pkg.sv ====
`include "dcache_params.svh"

package dcache_pkg;

    // stores have the top bit set
    typedef enum logic [3:0] {
        LB  = 4'h0,
        LH  = 4'h1,
        LW  = 4'h2,
        LBU = 4'h4,
        LHU = 4'h5,
        SB  = 4'h8,
        SH  = 4'h9,
        SW  = 4'ha
    } mem_op_e;

    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,
        WB_DROP,
        FILL_REQ,
        FILL_DROP,
        IO_REQ,
        IO_DROP,
        DONE
    } cache_state_e;

    typedef struct packed {
        logic                         valid;
        mem_op_e                      op;
        logic [`DCACHE_ADDR_WID-1:0]  addr;
        logic [`DCACHE_DATA_WID-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                         req;
        logic                         we;
        logic [`DCACHE_ADDR_WID-1:0]  addr;
        logic [`DCACHE_DATA_WID-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                         ack;
        logic [`DCACHE_DATA_WID-1:0]  rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [`DCACHE_TAG_WID-1:0]   tag;
        logic [`DCACHE_DATA_WID-1:0]  data;
    } cache_line_t;

    function automatic logic op_is_store(mem_op_e op);
        return op[3];
    endfunction

endpackage

// ==== rtl/lsu_lane_align.sv ====
`timescale 1ns/1ns
`include "dcache_params.svh"

module lsu_lane_align (
    input  dcache_pkg::mem_op_e            op,
    input  logic [1:0]                     byte_off,
    input  logic [`DCACHE_DATA_WID-1:0]    wdata,
    input  logic [`DCACHE_DATA_WID-1:0]    word_in,
    output logic [`DCACHE_DATA_WID-1:0]    load_data,
    output logic [`DCACHE_DATA_WID-1:0]    store_word
);
    import dcache_pkg::*;

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // pick the addressed byte and halfword out of the word
    always_comb begin
        unique case (byte_off)
            2'b00: lane_byte = word_in[7:0];
            2'b01: lane_byte = word_in[15:8];
            2'b10: lane_byte = word_in[23:16];
            default: lane_byte = word_in[31:24];
        endcase
        lane_half = byte_off[1] ? word_in[31:16] : word_in[15:0];
    end

    // load extension
    always_comb begin
        case (op)
            LB: begin
                load_data = {{24{lane_byte[7]}}, lane_byte};
            end
            LBU: begin
                load_data = {24'h000000, lane_byte};
            end
            LH: begin
                load_data = {{16{lane_half[15]}}, lane_half};
            end
            LHU: begin
                load_data = {16'h0000, lane_half};
            end
            default: begin
                load_data = word_in;
            end
        endcase
    end

    // store merge, untouched lanes keep word_in
    always_comb begin
        store_word = word_in;
        case (op)
            SB: begin
                case (byte_off)
                    2'b00: store_word[7:0] = wdata[7:0];
                    2'b01: store_word[15:8] = wdata[7:0];
                    2'b10: store_word[23:16] = wdata[7:0];
                    default: store_word[31:24] = wdata[7:0];
                endcase
            end
            SH: begin
                if (byte_off[1]) begin
                    store_word[31:16] = wdata[15:0];
                end else begin
                    store_word[15:0] = wdata[15:0];
                end
            end
            SW: begin
                store_word = wdata;
            end
            default: begin
                store_word = word_in;
            end
        endcase
    end

    // the cpu only issues halfword accesses on even addresses
    always_comb begin
        assert #0 ($isunknown(op) || !(op inside {LH, LHU, SH}) || !byte_off[0])
            else $error("halfword access at odd byte offset %0d", byte_off);
    end

endmodule

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  dcache_pkg::cpu_req_t           cpu_req,
    input  logic [`DCACHE_DATA_WID-1:0]    merged_word,
    output logic [`DCACHE_DATA_WID-1:0]    word_out,
    output logic                           stall,
    output dcache_pkg::mem_req_t           ram_req,
    input  dcache_pkg::mem_rsp_t           ram_rsp,
    output dcache_pkg::mem_req_t           io_req,
    input  dcache_pkg::mem_rsp_t           io_rsp
);
    import dcache_pkg::*;

    localparam int LINES = 1 << `DCACHE_INDEX_WID;
    localparam int HI_WID = `DCACHE_ADDR_WID - 16;

    cache_line_t lines [LINES];
    cache_line_t victim;
    cache_line_t cur_line;
    cache_state_e state;
    cache_state_e state_nxt;
    logic [`DCACHE_DATA_WID-1:0] rsp_word;

    logic [`DCACHE_INDEX_WID-1:0] req_index;
    logic [`DCACHE_TAG_WID-1:0] req_tag;
    logic is_io;
    logic is_store;
    logic hit;
    logic fast_done;
    logic fill_we;
    logic store_we;

    assign req_index = cpu_req.addr[`DCACHE_INDEX_WID+1:2];
    assign req_tag = cpu_req.addr[15:`DCACHE_INDEX_WID+2];
    assign is_io = cpu_req.addr[19:16] == `MMIO_REGION;
    assign is_store = op_is_store(cpu_req.op);
    assign cur_line = lines[req_index];
    assign hit = cur_line.valid && cur_line.tag == req_tag;

    // hits finish in the request cycle, everything else in DONE
    assign fast_done = state == IDLE && !is_io && hit;
    assign stall = cpu_req.valid && !fast_done && state != DONE;

    // io stores merge against zero
    assign word_out = (state == DONE) ? rsp_word : (is_io ? '0 : cur_line.data);

    assign fill_we = state == FILL_REQ && ram_rsp.ack;
    assign store_we = cpu_req.valid && is_store && !is_io && (fast_done || state == DONE);

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE: begin
                if (stall) begin
                    if (is_io) begin
                        state_nxt = IO_REQ;
                    end else if (cur_line.valid && cur_line.dirty) begin
                        state_nxt = WB_REQ;
                    end else begin
                        state_nxt = FILL_REQ;
                    end
                end
            end
            WB_REQ:    if (ram_rsp.ack) state_nxt = WB_DROP;
            WB_DROP:   if (!ram_rsp.ack) state_nxt = FILL_REQ;
            FILL_REQ:  if (ram_rsp.ack) state_nxt = FILL_DROP;
            FILL_DROP: if (!ram_rsp.ack) state_nxt = DONE;
            IO_REQ:    if (io_rsp.ack) state_nxt = IO_DROP;
            IO_DROP:   if (!io_rsp.ack) state_nxt = DONE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        ram_req = '0;
        ram_req.req = state == WB_REQ || state == FILL_REQ;
        if (state == WB_REQ || state == WB_DROP) begin
            // evicted word goes back to its own address
            ram_req.we = 1'b1;
            ram_req.addr = {{HI_WID{1'b0}}, victim.tag, req_index, 2'b00};
            ram_req.wdata = victim.data;
        end else begin
            ram_req.addr = {{HI_WID{1'b0}}, req_tag, req_index, 2'b00};
        end
    end

    assign io_req = '{
        req:   state == IO_REQ,
        we:    is_store,
        addr:  cpu_req.addr,
        wdata: merged_word
    };

    always_ff @(posedge clk) begin
        if (state == IDLE && stall) begin
            victim <= cur_line;
        end
        if (fill_we) begin
            rsp_word <= ram_rsp.rdata;
        end else if (state == IO_REQ && io_rsp.ack) begin
            rsp_word <= io_rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else if (fill_we) begin
            lines[req_index] <= '{valid: 1'b1, dirty: 1'b0, tag: req_tag, data: ram_rsp.rdata};
        end else if (store_we) begin
            lines[req_index] <= '{valid: 1'b1, dirty: 1'b1, tag: req_tag, data: merged_word};
        end
    end

    // a new request waits for the previous ack to fall
    assert property (@(posedge clk) disable iff (rst)
        !ram_req.req && ram_rsp.ack |=> !ram_req.req)
        else $error("ram req raised while ack still high");

    assert property (@(posedge clk) disable iff (rst)
        !io_req.req && io_rsp.ack |=> !io_req.req)
        else $error("io req raised while ack still high");

    // cpu must hold its request through a stall
    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(cpu_req))
        else $error("cpu request changed during stall");

endmodule

// ==== rtl/backing_ram.sv ====
`timescale 1ns/1ns
`include "dcache_params.svh"

module backing_ram (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::mem_req_t   req,
    output dcache_pkg::mem_rsp_t   rsp
);

    localparam int WORD_AW = $clog2(`RAM_WORDS);
    localparam int CNT_WID = $clog2(`RAM_LATENCY + 1);

    logic [`DCACHE_DATA_WID-1:0] mem [`RAM_WORDS];
    logic [CNT_WID-1:0] cnt;
    logic ack_q;
    logic [`DCACHE_DATA_WID-1:0] rdata_q;
    logic fire;

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // access happens in the cycle ack goes up
    assign fire = req.req && !ack_q && cnt == CNT_WID'(`RAM_LATENCY - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            ack_q <= 1'b0;
        end else if (!req.req) begin
            cnt <= '0;
            ack_q <= 1'b0;
        end else if (fire) begin
            cnt <= '0;
            ack_q <= 1'b1;
        end else if (!ack_q) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (req.we) begin
                mem[req.addr[WORD_AW+1:2]] <= req.wdata;
            end
            rdata_q <= mem[req.addr[WORD_AW+1:2]];
        end
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_top (
    input  logic                           clk,
    input  logic                           rst,
    input  dcache_pkg::cpu_req_t           cpu_req,
    output logic [`DCACHE_DATA_WID-1:0]    rdata,
    output logic                           stall,
    output dcache_pkg::mem_req_t           io_req,
    input  dcache_pkg::mem_rsp_t           io_rsp
);
    import dcache_pkg::*;

    logic [`DCACHE_DATA_WID-1:0] word_out;
    logic [`DCACHE_DATA_WID-1:0] merged_word;
    mem_req_t ram_req;
    mem_rsp_t ram_rsp;

    dcache_ctrl i_dcache_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .merged_word (merged_word),
        .word_out    (word_out),
        .stall       (stall),
        .ram_req     (ram_req),
        .ram_rsp     (ram_rsp),
        .io_req      (io_req),
        .io_rsp      (io_rsp)
    );

    lsu_lane_align i_lsu_lane_align (
        .op         (cpu_req.op),
        .byte_off   (cpu_req.addr[1:0]),
        .wdata      (cpu_req.wdata),
        .word_in    (word_out),
        .load_data  (rdata),
        .store_word (merged_word)
    );

    backing_ram i_backing_ram (
        .clk (clk),
        .rst (rst),
        .req (ram_req),
        .rsp (ram_rsp)
    );

endmodule

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        logic        expect_io;
        logic        hit;
    } entry_t;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    logic [31:0] rdata;
    logic        stall;
    mem_req_t    io_req;
    mem_rsp_t    io_rsp;

    entry_t      table_q[$];
    string       name_q[$];
    logic [31:0] model_mem [int];

    // mmio device state
    int          io_count;
    int          io_phase;
    int          io_delay;
    logic [31:0] rng;
    logic        rec_we;
    logic [31:0] rec_addr;
    logic [31:0] rec_data;

    dcache_top i_dcache_top (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .rdata   (rdata),
        .stall   (stall),
        .io_req  (io_req),
        .io_rsp  (io_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // device read data depends on the word address
    function automatic logic [31:0] io_pattern(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        return {~w[15:0], w[15:0]};
    endfunction

    function automatic logic store_op(input mem_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic logic [31:0] merge_lane(input mem_op_e op, input logic [1:0] off,
                                               input logic [31:0] old, input logic [31:0] wd);
        logic [31:0] w;
        w = old;
        case (op)
            SB: w[off*8 +: 8] = wd[7:0];
            SH: w[off[1]*16 +: 16] = wd[15:0];
            SW: w = wd;
            default: w = old;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] extend_lane(input mem_op_e op, input logic [1:0] off,
                                                input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[off*8 +: 8];
        h = word[off[1]*16 +: 16];
        case (op)
            LB: return {{24{b[7]}}, b};
            LBU: return {24'h0, b};
            LH: return {{16{h[15]}}, h};
            LHU: return {16'h0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        if (model_mem.exists(int'(a[15:2]))) begin
            return model_mem[int'(a[15:2])];
        end
        return 32'h0;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected %08h actual %08h", name, expected, actual));
        end
    endtask

    task automatic add_entry(input string name, input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp,
                             input logic expect_io, input logic hit);
        table_q.push_back('{op: op, addr: addr, wdata: wdata, exp: exp,
                            expect_io: expect_io, hit: hit});
        name_q.push_back(name);
    endtask

    task automatic build_table();
        add_entry("fresh_lw", LW, 32'h0000_0100, 32'h0, 32'h0000_0000, 0, 0);
        add_entry("sw_a", SW, 32'h0000_0040, 32'h1234_5678, 32'h0, 0, 0);
        add_entry("lw_a", LW, 32'h0000_0040, 32'h0, 32'h1234_5678, 0, 1);
        add_entry("lw_a_again", LW, 32'h0000_0040, 32'h0, 32'h1234_5678, 0, 1);
        // byte lanes of one word
        add_entry("sb_0", SB, 32'h0000_0080, 32'h1234_56ee, 32'h0, 0, 0);
        add_entry("sb_1", SB, 32'h0000_0081, 32'h0000_0081, 32'h0, 0, 1);
        add_entry("sb_2", SB, 32'h0000_0082, 32'hffff_ff7f, 32'h0, 0, 1);
        add_entry("sb_3", SB, 32'h0000_0083, 32'h0000_00c4, 32'h0, 0, 1);
        add_entry("lb_0", LB, 32'h0000_0080, 32'h0, 32'hffff_ffee, 0, 1);
        add_entry("lbu_0", LBU, 32'h0000_0080, 32'h0, 32'h0000_00ee, 0, 1);
        add_entry("lb_1", LB, 32'h0000_0081, 32'h0, 32'hffff_ff81, 0, 1);
        add_entry("lb_2", LB, 32'h0000_0082, 32'h0, 32'h0000_007f, 0, 1);
        add_entry("lbu_3", LBU, 32'h0000_0083, 32'h0, 32'h0000_00c4, 0, 1);
        add_entry("lw_bytes", LW, 32'h0000_0080, 32'h0, 32'hc47f_81ee, 0, 1);
        // halfword lanes
        add_entry("sh_0", SH, 32'h0000_0084, 32'h1111_9abc, 32'h0, 0, 0);
        add_entry("sh_2", SH, 32'h0000_0086, 32'h0000_7654, 32'h0, 0, 1);
        add_entry("lh_0", LH, 32'h0000_0084, 32'h0, 32'hffff_9abc, 0, 1);
        add_entry("lhu_0", LHU, 32'h0000_0084, 32'h0, 32'h0000_9abc, 0, 1);
        add_entry("lh_2", LH, 32'h0000_0086, 32'h0, 32'h0000_7654, 0, 1);
        add_entry("lhu_2", LHU, 32'h0000_0086, 32'h0, 32'h0000_7654, 0, 1);
        add_entry("lw_halves", LW, 32'h0000_0084, 32'h0, 32'h7654_9abc, 0, 1);
        // same index and another tag forces dirty writebacks
        add_entry("lw_b_evict", LW, 32'h0000_1040, 32'h0, 32'h0000_0000, 0, 0);
        add_entry("sw_b", SW, 32'h0000_1040, 32'hdead_beef, 32'h0, 0, 1);
        add_entry("lw_a_back", LW, 32'h0000_0040, 32'h0, 32'h1234_5678, 0, 0);
        add_entry("lw_b_back", LW, 32'h0000_1040, 32'h0, 32'hdead_beef, 0, 0);
        add_entry("sw_c_evict", SW, 32'h0000_2080, 32'h0bad_cafe, 32'h0, 0, 0);
        add_entry("lw_bytes_back", LW, 32'h0000_0080, 32'h0, 32'hc47f_81ee, 0, 0);
        add_entry("lw_c_back", LW, 32'h0000_2080, 32'h0, 32'h0bad_cafe, 0, 0);
        // mmio region
        add_entry("io_sw", SW, 32'h000f_0010, 32'ha1b2_c3d4, 32'h0, 1, 0);
        add_entry("io_sb", SB, 32'h000f_0013, 32'h0000_005e, 32'h0, 1, 0);
        add_entry("io_sh", SH, 32'h000f_0016, 32'hffff_1357, 32'h0, 1, 0);
        add_entry("io_lw", LW, 32'h000f_0020, 32'h0, 32'hffdf_0020, 1, 0);
        add_entry("io_lb", LB, 32'h000f_1236, 32'h0, 32'hffff_ffcb, 1, 0);
        add_entry("io_lbu", LBU, 32'h000f_1236, 32'h0, 32'h0000_00cb, 1, 0);
        add_entry("io_lhu", LHU, 32'h000f_1236, 32'h0, 32'h0000_edcb, 1, 0);
        add_entry("io_lh", LH, 32'h000f_1234, 32'h0, 32'h0000_1234, 1, 0);
    endtask

    task automatic run_entry(input int k);
        entry_t      e;
        string       name;
        int          waits;
        int          io_before;
        logic [31:0] word;
        logic [31:0] model_val;
        e = table_q[k];
        name = name_q[k];
        @(negedge clk);
        cpu_req = '{valid: 1'b1, op: e.op, addr: e.addr, wdata: e.wdata};
        io_before = io_count;
        waits = 0;
        #1;
        while (stall) begin
            if (waits >= WAIT_LIMIT) begin
                fail_run($sformatf("timeout: stall never fell for access %s", name));
            end
            @(negedge clk);
            #1;
            waits++;
        end
        check_value({name, " hit"}, {31'b0, e.hit}, {31'b0, waits == 0});
        check_value({name, " io count"}, {31'b0, e.expect_io}, io_count - io_before);
        if (e.expect_io) begin
            check_value({name, " io we"}, {31'b0, store_op(e.op)}, {31'b0, rec_we});
        end
        if (store_op(e.op)) begin
            if (e.expect_io) begin
                check_value({name, " io addr"}, e.addr, rec_addr);
                check_value({name, " io data"}, merge_lane(e.op, e.addr[1:0], 32'h0, e.wdata),
                            rec_data);
            end else begin
                model_mem[int'(e.addr[15:2])] = merge_lane(e.op, e.addr[1:0],
                                                           model_read(e.addr), e.wdata);
            end
        end else begin
            word = e.expect_io ? io_pattern(e.addr) : model_read(e.addr);
            model_val = extend_lane(e.op, e.addr[1:0], word);
            check_value({name, " model"}, e.exp, model_val);
            check_value(name, e.exp, rdata);
        end
        // the access completes at this edge
        @(posedge clk);
    endtask

    // mmio device acking after a pseudo random number of cycles
    initial begin
        io_rsp = '0;
        io_count = 0;
        io_phase = 0;
        io_delay = 0;
        rng = 32'hf269;
        rec_we = 1'b0;
        rec_addr = '0;
        rec_data = '0;
        forever begin
            @(negedge clk);
            case (io_phase)
                0: begin
                    if (io_req.req === 1'b1 && !rst) begin
                        io_count++;
                        rec_we = io_req.we;
                        if (io_req.we) begin
                            rec_addr = io_req.addr;
                            rec_data = io_req.wdata;
                        end
                        rng = lcg_next(rng);
                        io_delay = int'(rng[18:16]);
                        io_phase = 1;
                    end
                end
                1: begin
                    if (io_delay == 0) begin
                        io_rsp.ack = 1'b1;
                        io_rsp.rdata = io_pattern(io_req.addr);
                        io_phase = 2;
                    end else begin
                        io_delay--;
                    end
                end
                default: begin
                    if (!io_req.req) begin
                        io_rsp.ack = 1'b0;
                        io_phase = 0;
                    end
                end
            endcase
        end
    end

    initial begin
        rst = 1'b1;
        cpu_req = '0;
        build_table();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        #1;
        check_value("idle stall", 32'h0, {31'b0, stall});
        check_value("idle io req", 32'h0, {31'b0, io_req.req});
        for (int k = 0; k < table_q.size(); k++) begin
            run_entry(k);
        end
        @(negedge clk);
        cpu_req = '0;
        #1;
        check_value("final stall", 32'h0, {31'b0, stall});
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/lsu_lane_align.sv
rtl/dcache_ctrl.sv
rtl/backing_ram.sv
rtl/dcache_top.sv
sim/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dcache_pkg.sv
      - rtl/lsu_lane_align.sv
      - rtl/dcache_ctrl.sv
      - rtl/backing_ram.sv
      - rtl/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_tb.sv
